/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Physical address width of the instruction bus
`define FETCH_PHYS_BITS 20

// Bus word, segment and offset width
`define FETCH_WORD_BITS 16

// One prefetch FIFO entry
`define FETCH_BYTE_BITS 8

`define FETCH_FIFO_DEPTH 6

// Execution starts at FFFF:0000 out of reset
`define FETCH_RESET_CS 16'hFFFF
`define FETCH_RESET_IP 16'h0000

`endif

/* fetch_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [`FETCH_WORD_BITS-1:0] seg_off_t;

    typedef logic [`FETCH_BYTE_BITS-1:0] byte_t;

    // New CS:IP carried with the load strobe
    typedef struct packed {
        seg_off_t cs;
        seg_off_t ip;
    } csip_t;

    // Instruction bus request, word addressed
    typedef struct packed {
        logic [`FETCH_PHYS_BITS-1:1] addr;
        logic access;
    } imem_req_t;

    // Instruction bus response, data valid with ack
    typedef struct packed {
        logic [`FETCH_WORD_BITS-1:0] data;
        logic ack;
    } imem_rsp_t;

    typedef struct packed {
        logic start;
        logic is_8bit;
    } immed_req_t;

endpackage

`default_nettype wire

/* prefetch_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module prefetch_fifo (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             wr_en,
    input  fetch_pkg::byte_t wr_data,
    input  logic             rd_en,
    output fetch_pkg::byte_t rd_data,
    output logic             empty,
    output logic             nearly_full
);

    localparam int PTR_BITS = $clog2(`FETCH_FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`FETCH_FIFO_DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_IDX = PTR_BITS'(`FETCH_FIFO_DEPTH - 1);
    localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(`FETCH_FIFO_DEPTH);
    localparam logic [CNT_BITS-1:0] NEARLY_FULL_COUNT = CNT_BITS'(`FETCH_FIFO_DEPTH - 2);

    fetch_pkg::byte_t mem [`FETCH_FIFO_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_wr;
    logic do_rd;

    assign empty = count == '0;
    // Two free slots left, enough for one more word in flight
    assign nearly_full = count >= NEARLY_FULL_COUNT;
    assign rd_data = mem[rd_ptr];

    assign do_wr = wr_en && count != FULL_COUNT;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* prefetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module prefetch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  fetch_pkg::csip_t     new_csip,
    output fetch_pkg::imem_req_t imem_req,
    input  fetch_pkg::imem_rsp_t imem_rsp,
    output logic                 fifo_wr_en,
    output fetch_pkg::byte_t     fifo_wr_data,
    output logic                 fifo_flush,
    input  logic                 fifo_nearly_full
);

    localparam int SEG_SHIFT = `FETCH_PHYS_BITS - `FETCH_WORD_BITS;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_push_high
    } state_t;

    state_t state;
    fetch_pkg::seg_off_t fetch_cs;
    fetch_pkg::seg_off_t fetch_offset;
    fetch_pkg::seg_off_t next_offset;
    fetch_pkg::byte_t high_byte;
    logic [`FETCH_PHYS_BITS-1:0] phys_addr;
    logic [`FETCH_PHYS_BITS-1:1] req_addr;
    logic discard;
    logic ack_cycle;
    logic keep_word;

    // cs * 16 + offset, wrapping at the top of the physical space
    assign phys_addr = {fetch_cs, {SEG_SHIFT{1'b0}}}
                     + {{SEG_SHIFT{1'b0}}, fetch_offset};

    // Round up to the next even offset, wraps inside the segment
    assign next_offset = (fetch_offset | fetch_pkg::seg_off_t'(1))
                       + fetch_pkg::seg_off_t'(1);

    assign imem_req.addr = req_addr;
    assign imem_req.access = state == st_access;

    assign fifo_flush = load;

    assign ack_cycle = state == st_access && imem_rsp.ack;
    // A word requested before a load never reaches the FIFO
    assign keep_word = ack_cycle && !discard && !load;

    always_comb begin
        fifo_wr_en = 1'b0;
        fifo_wr_data = high_byte;
        if (keep_word) begin
            fifo_wr_en = 1'b1;
            // Odd start skips the low byte of the word
            fifo_wr_data = fetch_offset[0] ?
                imem_rsp.data[`FETCH_WORD_BITS-1:`FETCH_BYTE_BITS] :
                imem_rsp.data[`FETCH_BYTE_BITS-1:0];
        end else if (state == st_push_high && !load) begin
            fifo_wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            discard <= 1'b0;
            fetch_cs <= `FETCH_RESET_CS;
            fetch_offset <= `FETCH_RESET_IP;
        end else begin
            if (load) begin
                fetch_cs <= new_csip.cs;
                fetch_offset <= new_csip.ip;
            end else if (keep_word) begin
                fetch_offset <= next_offset;
            end

            case (state)
                st_idle: begin
                    if (!load && !fifo_nearly_full)
                        state <= st_access;
                end
                st_access: begin
                    if (ack_cycle) begin
                        discard <= 1'b0;
                        state <= (keep_word && !fetch_offset[0]) ?
                            st_push_high : st_idle;
                    end else if (load) begin
                        // Bus must still complete, the word is dropped
                        discard <= 1'b1;
                    end
                end
                st_push_high: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Address held stable for the whole access
    always_ff @(posedge clk) begin
        if (state == st_idle)
            req_addr <= phys_addr[`FETCH_PHYS_BITS-1:1];
        if (keep_word)
            high_byte <= imem_rsp.data[`FETCH_WORD_BITS-1:`FETCH_BYTE_BITS];
    end

endmodule

`default_nettype wire

/* immediate_reader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module immediate_reader (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  fetch_pkg::seg_off_t   new_ip,
    input  fetch_pkg::immed_req_t immed_req,
    output logic                  busy,
    output logic                  complete,
    output fetch_pkg::seg_off_t   immediate,
    output fetch_pkg::seg_off_t   ip,
    output logic                  fifo_rd_en,
    input  fetch_pkg::byte_t      fifo_rd_data,
    input  logic                  fifo_empty
);

    localparam int EXT_BITS = `FETCH_WORD_BITS - `FETCH_BYTE_BITS;

    logic is_8bit_r;
    logic second_byte;
    logic last_pop;

    // Stale bytes are flushed on load, so no pop that cycle
    assign fifo_rd_en = busy && !fifo_empty && !load;
    assign last_pop = fifo_rd_en && (is_8bit_r || second_byte);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            complete <= 1'b0;
            is_8bit_r <= 1'b0;
            second_byte <= 1'b0;
            ip <= `FETCH_RESET_IP;
        end else begin
            complete <= 1'b0;
            if (load) begin
                busy <= 1'b0;
                second_byte <= 1'b0;
                ip <= new_ip;
            end else begin
                if (fifo_rd_en)
                    ip <= ip + 1'b1;

                if (!busy && immed_req.start) begin
                    busy <= 1'b1;
                    is_8bit_r <= immed_req.is_8bit;
                    second_byte <= 1'b0;
                end else if (last_pop) begin
                    busy <= 1'b0;
                    complete <= 1'b1;
                    second_byte <= 1'b0;
                end else if (fifo_rd_en) begin
                    second_byte <= 1'b1;
                end
            end
        end
    end

    // Little endian, low byte arrives first
    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            if (second_byte)
                immediate[`FETCH_WORD_BITS-1:`FETCH_BYTE_BITS] <= fifo_rd_data;
            else
                immediate <= {{EXT_BITS{1'b0}}, fifo_rd_data};
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  fetch_pkg::csip_t      new_csip,
    output fetch_pkg::imem_req_t  imem_req,
    input  fetch_pkg::imem_rsp_t  imem_rsp,
    input  fetch_pkg::immed_req_t immed_req,
    output fetch_pkg::seg_off_t   immediate,
    output logic                  immed_busy,
    output logic                  immed_complete,
    output fetch_pkg::seg_off_t   ip
);

    logic fifo_wr_en;
    fetch_pkg::byte_t fifo_wr_data;
    logic fifo_flush;
    logic fifo_nearly_full;
    logic fifo_rd_en;
    fetch_pkg::byte_t fifo_rd_data;
    logic fifo_empty;

    prefetch prefetch_i (
        .clk(clk),
        .reset(reset),
        .load(load),
        .new_csip(new_csip),
        .imem_req(imem_req),
        .imem_rsp(imem_rsp),
        .fifo_wr_en(fifo_wr_en),
        .fifo_wr_data(fifo_wr_data),
        .fifo_flush(fifo_flush),
        .fifo_nearly_full(fifo_nearly_full)
    );

    prefetch_fifo prefetch_fifo_i (
        .clk(clk),
        .reset(reset),
        .flush(fifo_flush),
        .wr_en(fifo_wr_en),
        .wr_data(fifo_wr_data),
        .rd_en(fifo_rd_en),
        .rd_data(fifo_rd_data),
        .empty(fifo_empty),
        .nearly_full(fifo_nearly_full)
    );

    immediate_reader immediate_reader_i (
        .clk(clk),
        .reset(reset),
        .load(load),
        .new_ip(new_csip.ip),
        .immed_req(immed_req),
        .busy(immed_busy),
        .complete(immed_complete),
        .immediate(immediate),
        .ip(ip),
        .fifo_rd_en(fifo_rd_en),
        .fifo_rd_data(fifo_rd_data),
        .fifo_empty(fifo_empty)
    );

endmodule

`default_nettype wire

/* tb_fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_unit;

    localparam int HALF_PERIOD = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 8;
    localparam int BYTE_READS = 40;
    localparam int WORD_READS = 30;
    localparam int MIXED_READS = 60;
    localparam int BP_READS = 20;
    localparam int BP_IDLE_CYCLES = 60;
    localparam int CYCLE_LIMIT =
        20 * (BYTE_READS + WORD_READS + MIXED_READS + BP_READS) + 2000;

    logic clk;
    logic reset;
    logic load;
    fetch_pkg::csip_t new_csip;
    fetch_pkg::imem_req_t imem_req;
    fetch_pkg::imem_rsp_t imem_rsp;
    fetch_pkg::immed_req_t immed_req;
    fetch_pkg::seg_off_t immediate;
    logic immed_busy;
    logic immed_complete;
    fetch_pkg::seg_off_t ip;

    int errors = 0;
    int errors_at_start = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;
    int occupancy = 0;
    int max_occupancy = 0;
    logic overflow_seen = 1'b0;

    // Reference model state
    logic [7:0] exp_bytes [$];
    fetch_pkg::seg_off_t model_cs;
    fetch_pkg::seg_off_t fill_ip;
    fetch_pkg::seg_off_t exp_ip;

    fetch_unit dut_i (
        .clk(clk),
        .reset(reset),
        .load(load),
        .new_csip(new_csip),
        .imem_req(imem_req),
        .imem_rsp(imem_rsp),
        .immed_req(immed_req),
        .immediate(immediate),
        .immed_busy(immed_busy),
        .immed_complete(immed_complete),
        .ip(ip)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a read or bus access never finished", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Memory contents hashed from the full word address
    function automatic logic [15:0] mem_word(input logic [18:0] waddr);
        logic [31:0] x;
        x = {13'd0, waddr} * 32'h9e3779b1;
        return x[31:16] ^ x[15:0];
    endfunction

    function automatic logic [7:0] mem_byte(input logic [15:0] cs, input logic [15:0] off);
        logic [31:0] phys;
        logic [15:0] w;
        // Segment times 16 plus offset, modulo 1 MB
        phys = (32'(cs) * 32'd16 + 32'(off)) % 32'h100000;
        w = mem_word(phys[19:1]);
        return phys[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("FAIL t=%0t %s: expected %0h, got %0h", $time, name, exp_val, got_val);
        errors = errors + 1;
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Ack after 0 to 4 cycles with the address held
    initial begin : memory_responder
        int delay;
        logic pending;
        logic [18:0] held_addr;
        imem_rsp = '0;
        pending = 1'b0;
        delay = 0;
        held_addr = '0;
        forever begin
            step();
            if (imem_rsp.ack) begin
                imem_rsp.ack = 1'b0;
            end else if (imem_req.access === 1'b1) begin
                if (!pending) begin
                    pending = 1'b1;
                    held_addr = imem_req.addr;
                    delay = int'($urandom_range(4, 0));
                end
                if (imem_req.addr !== held_addr)
                    report_mismatch("imem_req.addr", 32'(held_addr), 32'(imem_req.addr));
                if (delay == 0) begin
                    imem_rsp.data = mem_word(imem_req.addr);
                    imem_rsp.ack = 1'b1;
                    pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

    // FIFO occupancy as seen at the next edge
    always @(negedge clk) begin
        if (reset || dut_i.fifo_flush) begin
            occupancy = 0;
        end else begin
            if (dut_i.fifo_wr_en)
                occupancy = occupancy + 1;
            if (dut_i.fifo_rd_en)
                occupancy = occupancy - 1;
        end
        if (occupancy > max_occupancy)
            max_occupancy = occupancy;
        if (occupancy > `FETCH_FIFO_DEPTH && !overflow_seen) begin
            $display("FAIL t=%0t fifo occupancy: expected <= %0d, got %0d",
                     $time, `FETCH_FIFO_DEPTH, occupancy);
            errors = errors + 1;
            overflow_seen = 1'b1;
        end
    end

    task automatic restart_model(input logic [15:0] cs, input logic [15:0] start_ip);
        model_cs = cs;
        fill_ip = start_ip;
        exp_ip = start_ip;
        exp_bytes.delete();
    endtask

    task automatic pop_expected(output logic [7:0] b);
        while (exp_bytes.size() < 4) begin
            exp_bytes.push_back(mem_byte(model_cs, fill_ip));
            fill_ip = fill_ip + 16'd1;
        end
        b = exp_bytes.pop_front();
        exp_ip = exp_ip + 16'd1;
    endtask

    task automatic load_csip(input logic [15:0] cs, input logic [15:0] start_ip);
        step();
        load = 1'b1;
        new_csip.cs = cs;
        new_csip.ip = start_ip;
        step();
        load = 1'b0;
        restart_model(cs, start_ip);
        if (ip !== start_ip)
            report_mismatch("ip", 32'(start_ip), 32'(ip));
    endtask

    task automatic read_immediate(input logic is_8bit);
        logic [7:0] lo;
        logic [7:0] hi;
        logic [15:0] exp_val;
        step();
        immed_req.start = 1'b1;
        immed_req.is_8bit = is_8bit;
        step();
        immed_req.start = 1'b0;
        if (immed_busy !== 1'b1)
            report_mismatch("immed_busy", 32'd1, 32'(immed_busy));
        pop_expected(lo);
        hi = 8'h00;
        if (!is_8bit)
            pop_expected(hi);
        exp_val = {hi, lo};
        while (immed_complete !== 1'b1)
            step();
        if (immediate !== exp_val)
            report_mismatch("immediate", 32'(exp_val), 32'(immediate));
        if (immed_busy !== 1'b0)
            report_mismatch("immed_busy", 32'd0, 32'(immed_busy));
        if (ip !== exp_ip)
            report_mismatch("ip", 32'(exp_ip), 32'(ip));
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
            tests_ok = tests_ok + 1;
        end else begin
            $display("%s: %0d errors", name, errors - errors_at_start);
            tests_bad = tests_bad + 1;
        end
        errors_at_start = errors;
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            step();
            if (imem_req.access !== 1'b0)
                report_mismatch("imem_req.access", 32'd0, 32'(imem_req.access));
            if (immed_busy !== 1'b0)
                report_mismatch("immed_busy", 32'd0, 32'(immed_busy));
            if (immed_complete !== 1'b0)
                report_mismatch("immed_complete", 32'd0, 32'(immed_complete));
            if (ip !== `FETCH_RESET_IP)
                report_mismatch("ip", 32'(`FETCH_RESET_IP), 32'(ip));
        end
        reset = 1'b0;
        while (imem_req.access !== 1'b1)
            step();
        // FFFF:0000 is physical FFFF0
        if (imem_req.addr !== 19'h7FFF8)
            report_mismatch("imem_req.addr", 32'h7FFF8, 32'(imem_req.addr));
    endtask

    task automatic run_mixed_reads();
        logic [15:0] start_ip;
        load_csip(16'($urandom), 16'hFFFC);
        for (int i = 0; i < MIXED_READS; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                // Half the loads land just below the segment wrap
                if ($urandom_range(1, 0) == 1)
                    start_ip = 16'hFFF8 | 16'($urandom_range(7, 0));
                else
                    start_ip = 16'($urandom);
                load_csip(16'($urandom), start_ip);
            end
            read_immediate($urandom_range(1, 0) == 1);
        end
    endtask

    task automatic run_back_pressure();
        load_csip(16'($urandom), 16'($urandom));
        max_occupancy = 0;
        repeat (BP_IDLE_CYCLES) step();
        if (max_occupancy > `FETCH_FIFO_DEPTH || max_occupancy < `FETCH_FIFO_DEPTH - 2) begin
            $display("FAIL t=%0t fifo occupancy: expected %0d to %0d, got %0d", $time,
                     `FETCH_FIFO_DEPTH - 2, `FETCH_FIFO_DEPTH, max_occupancy);
            errors = errors + 1;
        end
        for (int i = 0; i < BP_READS; i++)
            read_immediate($urandom_range(1, 0) == 1);
    endtask

    initial begin
        void'($urandom(32'h90c8));
        reset = 1'b1;
        load = 1'b0;
        new_csip = '0;
        immed_req = '0;

        check_reset_state();
        finish_test("reset state");

        load_csip(16'($urandom), 16'($urandom) & 16'hFFFE);
        for (int i = 0; i < BYTE_READS; i++)
            read_immediate(1'b1);
        finish_test("byte reads");

        load_csip(16'($urandom), 16'($urandom) | 16'h0001);
        for (int i = 0; i < WORD_READS; i++)
            read_immediate(1'b0);
        finish_test("word reads, odd start");

        run_mixed_reads();
        finish_test("reloads and wrap");

        run_back_pressure();
        finish_test("back-pressure");

        $display("%0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_unit.f */
+incdir+.
fetch_pkg.sv
prefetch_fifo.sv
prefetch.sv
immediate_reader.sv
fetch_unit.sv
tb_fetch_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f fetch_unit.f \
    --top-module tb_fetch_unit \
    -o sim_fetch_unit

./obj_dir/sim_fetch_unit | tee "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished, no failure found in $LOG"
exit 0
